/* compile.f */
hdl/dcache_pkg.sv
hdl/victim_lfsr.sv
hdl/dcache_way.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
bench/clk_gen.sv
bench/mem_model.sv
bench/dcache_tb.sv

/* bench/dcache_tb.sv */
`timescale 1ns/100ps

module dcache_tb
    import dcache_pkg::*;
();

    localparam word_t PATTERN = 32'h5A3C_96E1;
    localparam int    TIMEOUT = 2000;

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    logic        req_ready;
    logic        req_write;
    logic [31:0] req_addr;
    word_t       req_wdata;
    logic [3:0]  req_wstrb;
    logic        resp_valid;
    logic        resp_ready;
    word_t       resp_rdata;
    logic        mem_valid;
    logic        mem_ready;
    logic        mem_write;
    logic [31:0] mem_addr;
    word_t       mem_wdata;
    logic        mem_rvalid;
    word_t       mem_rdata;

    word_t       shadow [16384];
    bit          wb_line [4096];
    bit          hung;
    int          errors;
    int          checks;

    clk_gen #(
        .HALF_PERIOD  (4),
        .RESET_CYCLES (5)
    ) u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    dcache_top #(
        .WAY_NUM (4)
    ) DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_wstrb  (req_wstrb),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_rdata (resp_rdata),
        .mem_valid  (mem_valid),
        .mem_ready  (mem_ready),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata)
    );

    mem_model #(
        .PATTERN (PATTERN)
    ) u_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_valid  (mem_valid),
        .mem_ready  (mem_ready),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata)
    );

    // lines that saw a writeback beat
    always @(posedge clk) begin
        if (mem_valid && mem_ready && mem_write) begin
            wb_line[mem_addr[15:4]] <= 1'b1;
        end
    end

    resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp_rdata)))
    else begin
        errors++;
        $display("response dropped or resp_rdata changed while resp_ready was low");
    end

    mem_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_valid && !mem_ready) |=> (mem_valid && $stable(mem_addr)
            && $stable(mem_write) && $stable(mem_wdata)))
    else begin
        errors++;
        $display("memory beat changed while mem_ready was low");
    end

    busy_low: assert property (@(posedge clk) disable iff (!rst_n)
        ((req_valid && req_ready) || (!req_ready && !(resp_valid && resp_ready)))
            |=> !req_ready)
    else begin
        errors++;
        $display("req_ready rose while a request was outstanding");
    end

    ready_back: assert property (@(posedge clk) disable iff (!rst_n)
        (resp_valid && resp_ready) |=> req_ready)
    else begin
        errors++;
        $display("req_ready did not return after the response handshake");
    end

    resp_only_busy: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> !req_ready)
    else begin
        errors++;
        $display("resp_valid high while the cache was taking requests");
    end

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (hung) begin
            return;
        end
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("FAIL %s expected %h actual %h", name, exp, act);
        end
    endtask

    // one request and its response; lat counts edges with resp_valid low
    task automatic access(input logic wr, input logic [31:0] addr, input word_t wd,
                          input logic [3:0] ws, input logic hold,
                          output word_t rd, output int lat);
        int n;
        rd  = '0;
        lat = 0;
        if (hung) begin
            return;
        end
        req_valid <= 1'b1;
        req_write <= wr;
        req_addr  <= addr;
        req_wdata <= wd;
        req_wstrb <= ws;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!req_ready && n < TIMEOUT);
        req_valid <= 1'b0;
        if (!req_ready) begin
            hung = 1'b1;
            errors++;
            $display("request to %h was never accepted", addr);
            return;
        end
        n = 0;
        do begin
            resp_ready <= hold || ($urandom_range(3, 0) != 0);
            @(posedge clk);
            n++;
            if (!resp_valid) begin
                lat++;
            end
        end while (!(resp_valid && resp_ready) && n < TIMEOUT);
        if (resp_valid && resp_ready) begin
            rd = resp_rdata;
        end else begin
            hung = 1'b1;
            errors++;
            $display("no response came for the request to %h", addr);
        end
    endtask

    task automatic write_word(input logic [31:0] addr, input word_t wd, input logic [3:0] ws);
        word_t rd;
        int    lat;
        access(1'b1, addr, wd, ws, 1'b0, rd, lat);
        for (int b = 0; b < 4; b++) begin
            if (ws[b]) begin
                shadow[addr[15:2]][8*b +: 8] = wd[8*b +: 8];
            end
        end
    endtask

    task automatic read_check(input string name, input logic [31:0] addr);
        word_t rd;
        int    lat;
        access(1'b0, addr, '0, 4'h0, 1'b0, rd, lat);
        check_word(name, shadow[addr[15:2]], rd);
    endtask

    task automatic report_test(input string name, input int base);
        $display("test %-12s errors %0d", name, errors - base);
    endtask

    initial begin
        int          n;
        int          lat;
        int          base;
        int          nwb;
        word_t       rd;
        logic [31:0] a;

        void'($urandom(34598));
        req_valid  = 1'b0;
        req_write  = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        req_wstrb  = '0;
        resp_ready = 1'b0;
        for (int i = 0; i < 16384; i++) begin
            shadow[i] = word_t'(i) ^ PATTERN;
        end

        n = 0;
        while (rst_n !== 1'b1 && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        @(posedge clk);
        base = errors;
        if (rst_n !== 1'b1) begin
            hung = 1'b1;
            errors++;
            $display("reset was never released");
        end
        check_word("reset_req_ready", 32'd1, word_t'(req_ready));
        check_word("reset_resp_valid", 32'd0, word_t'(resp_valid));
        check_word("reset_mem_valid", 32'd0, word_t'(mem_valid));
        report_test("reset", base);

        base = errors;
        for (int k = 0; k < 8; k++) begin
            read_check("cold_read", 32'h4000 + k * 32'h124);
        end
        report_test("cold_read", base);

        // partial write allocates on a miss, then merges on a hit
        base = errors;
        write_word(32'h0308, 32'hA1B2_C3D4, 4'b0101);
        read_check("strobe_miss", 32'h0308);
        write_word(32'h0308, 32'h5566_7788, 4'b1010);
        read_check("strobe_hit", 32'h0308);
        read_check("strobe_line", 32'h0300);
        report_test("strobe", base);

        base = errors;
        read_check("hit_latency", 32'h5000);
        access(1'b0, 32'h5004, '0, 4'h0, 1'b1, rd, lat);
        check_word("hit_latency", shadow[32'h5004 >> 2], rd);
        check_word("hit_latency_cycles", 32'd2, word_t'(lat));
        report_test("hit_latency", base);

        // six dirty lines in set 5, four ways
        base = errors;
        for (int t = 1; t <= 6; t++) begin
            a = (t << 10) | 32'h50;
            write_word(a, 32'hE000_0000 | t, 4'hF);
            write_word(a + 8, $urandom, 4'b0110);
        end
        for (int t = 1; t <= 6; t++) begin
            a = (t << 10) | 32'h50;
            read_check("evict", a);
            read_check("evict", a + 8);
        end
        nwb = 0;
        for (int t = 1; t <= 6; t++) begin
            a = (t << 10) | 32'h50;
            if (wb_line[a[15:4]]) begin
                nwb++;
                for (int w = 0; w < 4; w++) begin
                    check_word("evict_mem", shadow[a[15:2] + w], u_mem.mem[a[15:2] + w]);
                end
            end
        end
        if (!hung) begin
            assert (nwb >= 2) else begin
                errors++;
                $display("fewer than two dirty lines were written back");
            end
        end
        report_test("evict", base);

        // eight tags over four sets
        base = errors;
        for (int i = 0; i < 200; i++) begin
            a = ($urandom_range(7, 0) << 10) | ($urandom_range(3, 0) << 4)
                | ($urandom_range(3, 0) << 2);
            if ($urandom_range(1, 0) == 1) begin
                write_word(a, $urandom, 4'($urandom_range(15, 0)));
            end else begin
                read_check("random", a);
            end
        end
        report_test("random", base);

        $display("checks %0d  errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* bench/mem_model.sv */
`timescale 1ns/100ps

module mem_model
    import dcache_pkg::*;
#(
    parameter word_t PATTERN = 32'h0
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        mem_valid,
    output logic        mem_ready,
    input  logic        mem_write,
    input  logic [31:0] mem_addr,
    input  word_t       mem_wdata,
    output logic        mem_rvalid,
    output word_t       mem_rdata
);

    localparam int WORDS = 16384;

    word_t       mem [WORDS];
    logic        ready_q  = 1'b0;
    logic        rvalid_q = 1'b0;
    word_t       rdata_q  = '0;
    logic        busy     = 1'b0;
    logic [1:0]  delay    = '0;
    logic [13:0] rd_idx   = '0;

    assign mem_ready  = ready_q;
    assign mem_rvalid = rvalid_q;
    assign mem_rdata  = rdata_q;

    // every word starts as its word address xor the pattern
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = word_t'(i) ^ PATTERN;
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready_q  <= 1'b0;
            rvalid_q <= 1'b0;
            busy     <= 1'b0;
        end else begin
            rvalid_q <= 1'b0;
            if (mem_valid && ready_q) begin
                ready_q <= 1'b0;
                if (mem_write) begin
                    mem[mem_addr[15:2]] <= mem_wdata;
                end else begin
                    busy   <= 1'b1;
                    delay  <= 2'($urandom_range(3, 0));
                    rd_idx <= mem_addr[15:2];
                end
            end else if (busy) begin
                // one read outstanding, ready stays low until it returns
                if (delay == 2'd0) begin
                    busy     <= 1'b0;
                    rvalid_q <= 1'b1;
                    rdata_q  <= mem[rd_idx];
                end else begin
                    delay <= delay - 2'd1;
                end
            end else begin
                // stall about one cycle in three
                ready_q <= ($urandom_range(2, 0) != 0);
            end
        end
    end

endmodule

/* bench/clk_gen.sv */
`timescale 1ns/100ps

module clk_gen #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    // release on a clock edge, after the reset cycles
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* hdl/dcache_top.sv */
`timescale 1ns/100ps

module dcache_top
    import dcache_pkg::*;
#(
    parameter int WAY_NUM = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  logic                 req_write,
    input  logic [ADDR_BITS-1:0] req_addr,
    input  word_t                req_wdata,
    input  logic [3:0]           req_wstrb,
    output logic                 resp_valid,
    input  logic                 resp_ready,
    output word_t                resp_rdata,
    output logic                 mem_valid,
    input  logic                 mem_ready,
    output logic                 mem_write,
    output logic [ADDR_BITS-1:0] mem_addr,
    output word_t                mem_wdata,
    input  logic                 mem_rvalid,
    input  word_t                mem_rdata
);

    logic [WAY_NUM-1:0]         way_en;
    logic [WAY_NUM-1:0]         way_valid;
    logic [WAY_NUM-1:0]         way_dirty;
    logic                       way_we;
    logic                       way_wdirty;
    logic [SET_BITS-1:0]        way_set;
    line_t                      way_wline;
    logic [TAG_BITS-1:0]        way_wtag;
    logic [TAG_BITS-1:0]        way_tag [WAY_NUM];
    line_t                      way_rline [WAY_NUM];
    logic [$clog2(WAY_NUM)-1:0] rand_way;

    dcache_ctrl #(
        .WAY_NUM (WAY_NUM)
    ) u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_wstrb  (req_wstrb),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_rdata (resp_rdata),
        .mem_valid  (mem_valid),
        .mem_ready  (mem_ready),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .rand_way   (rand_way),
        .way_en     (way_en),
        .way_we     (way_we),
        .way_set    (way_set),
        .way_wline  (way_wline),
        .way_wtag   (way_wtag),
        .way_wdirty (way_wdirty),
        .way_valid  (way_valid),
        .way_dirty  (way_dirty),
        .way_tag    (way_tag),
        .way_rline  (way_rline)
    );

    // shared write bus, per-way enable
    for (genvar w = 0; w < WAY_NUM; w++) begin : g_way
        dcache_way u_way (
            .clk    (clk),
            .rst_n  (rst_n),
            .en     (way_en[w]),
            .we     (way_we),
            .set    (way_set),
            .wline  (way_wline),
            .wtag   (way_wtag),
            .wdirty (way_wdirty),
            .valid  (way_valid[w]),
            .dirty  (way_dirty[w]),
            .tag    (way_tag[w]),
            .rline  (way_rline[w])
        );
    end

    victim_lfsr #(
        .WAY_NUM (WAY_NUM)
    ) u_lfsr (
        .clk      (clk),
        .rst_n    (rst_n),
        .rand_way (rand_way)
    );

endmodule

/* hdl/dcache_ctrl.sv */
`timescale 1ns/100ps

module dcache_ctrl
    import dcache_pkg::*;
#(
    parameter int WAY_NUM = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       req_valid,
    output logic                       req_ready,
    input  logic                       req_write,
    input  logic [ADDR_BITS-1:0]       req_addr,
    input  word_t                      req_wdata,
    input  logic [3:0]                 req_wstrb,
    output logic                       resp_valid,
    input  logic                       resp_ready,
    output word_t                      resp_rdata,
    output logic                       mem_valid,
    input  logic                       mem_ready,
    output logic                       mem_write,
    output logic [ADDR_BITS-1:0]       mem_addr,
    output word_t                      mem_wdata,
    input  logic                       mem_rvalid,
    input  word_t                      mem_rdata,
    input  logic [$clog2(WAY_NUM)-1:0] rand_way,
    output logic [WAY_NUM-1:0]         way_en,
    output logic                       way_we,
    output logic [SET_BITS-1:0]        way_set,
    output line_t                      way_wline,
    output logic [TAG_BITS-1:0]        way_wtag,
    output logic                       way_wdirty,
    input  logic [WAY_NUM-1:0]         way_valid,
    input  logic [WAY_NUM-1:0]         way_dirty,
    input  logic [TAG_BITS-1:0]        way_tag [WAY_NUM],
    input  line_t                      way_rline [WAY_NUM]
);

    localparam int WAY_BITS = $clog2(WAY_NUM);

    localparam logic [2:0] S_IDLE = 3'd0;
    localparam logic [2:0] S_CMP  = 3'd1;
    localparam logic [2:0] S_WB   = 3'd2;
    localparam logic [2:0] S_FILL = 3'd3;
    localparam logic [2:0] S_RESP = 3'd4;

    logic [2:0]             state;
    logic [TAG_BITS-1:0]    tag_q;
    logic [SET_BITS-1:0]    set_q;
    logic [OFFSET_BITS-1:0] off_q;
    logic                   write_q;
    word_t                  wdata_q;
    logic [3:0]             wstrb_q;
    logic [OFFSET_BITS-1:0] beat;
    logic [WAY_BITS-1:0]    victim_q;
    logic [TAG_BITS-1:0]    vtag_q;
    line_t                  vline_q;
    line_t                  fill_q;
    word_t                  rdata_q;

    logic [WAY_NUM-1:0]     hit;
    logic [WAY_BITS-1:0]    hit_idx;
    logic [WAY_BITS-1:0]    free_idx;
    logic                   any_free;
    logic [WAY_BITS-1:0]    pick;
    logic                   pick_dirty;
    logic                   is_hit;
    logic                   accept;
    logic                   mem_fire;
    logic                   last_beat;
    logic                   fill_done;
    line_t                  fill_next;
    line_t                  base_line;
    line_t                  merged;

    assign accept    = req_valid && req_ready;
    assign mem_fire  = mem_valid && mem_ready;
    assign last_beat = (beat == OFFSET_BITS'(LINE_WORDS - 1));
    assign fill_done = (state == S_FILL) && mem_rvalid && last_beat;
    assign is_hit    = |hit;

    // tag match, lowest invalid way as the free candidate
    always_comb begin
        hit      = '0;
        hit_idx  = '0;
        free_idx = '0;
        any_free = 1'b0;
        for (int w = WAY_NUM - 1; w >= 0; w--) begin
            hit[w] = way_valid[w] && (way_tag[w] == tag_q);
            if (hit[w]) begin
                hit_idx = WAY_BITS'(w);
            end
            if (!way_valid[w]) begin
                any_free = 1'b1;
                free_idx = WAY_BITS'(w);
            end
        end
    end

    assign pick       = any_free ? free_idx : rand_way;
    assign pick_dirty = way_valid[pick] && way_dirty[pick];

    always_comb begin
        fill_next             = fill_q;
        fill_next.words[beat] = mem_rdata;
    end

    assign base_line = (state == S_CMP) ? way_rline[hit_idx] : fill_next;

    // strobed byte merge, a no-op for reads
    always_comb begin
        merged = base_line;
        for (int b = 0; b < 4; b++) begin
            if (write_q && wstrb_q[b]) begin
                merged.words[off_q][8*b +: 8] = wdata_q[8*b +: 8];
            end
        end
    end

    assign way_set    = set_q;
    assign way_wtag   = tag_q;
    assign way_wdirty = write_q;
    assign way_wline  = merged;
    assign way_we     = ((state == S_CMP) && is_hit && write_q) || fill_done;
    assign way_en     = (state == S_CMP) ? hit : WAY_NUM'(1) << victim_q;

    assign mem_write  = (state == S_WB);
    assign mem_addr   = {(state == S_WB) ? vtag_q : tag_q, set_q, beat, 2'b00};
    assign mem_wdata  = vline_q.words[beat];
    assign resp_rdata = rdata_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            req_ready  <= 1'b1;
            resp_valid <= 1'b0;
            mem_valid  <= 1'b0;
            beat       <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    // second idle cycle lets the ways read the set
                    if (accept) begin
                        req_ready <= 1'b0;
                    end else if (!req_ready) begin
                        state <= S_CMP;
                    end
                end
                S_CMP: begin
                    beat <= '0;
                    if (is_hit) begin
                        state      <= S_RESP;
                        resp_valid <= 1'b1;
                    end else begin
                        mem_valid <= 1'b1;
                        state     <= pick_dirty ? S_WB : S_FILL;
                    end
                end
                S_WB: begin
                    // beat wraps to zero for the first refill read
                    if (mem_fire) begin
                        beat <= beat + 1'b1;
                        if (last_beat) begin
                            state <= S_FILL;
                        end
                    end
                end
                S_FILL: begin
                    if (mem_fire) begin
                        mem_valid <= 1'b0;
                    end
                    if (mem_rvalid) begin
                        beat <= beat + 1'b1;
                        if (last_beat) begin
                            state      <= S_RESP;
                            resp_valid <= 1'b1;
                        end else begin
                            mem_valid <= 1'b1;
                        end
                    end
                end
                S_RESP: begin
                    if (resp_ready) begin
                        resp_valid <= 1'b0;
                        req_ready  <= 1'b1;
                        state      <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            {tag_q, set_q, off_q} <= req_addr[ADDR_BITS-1:2];
            write_q               <= req_write;
            wdata_q               <= req_wdata;
            wstrb_q               <= req_wstrb;
        end
        if ((state == S_CMP) && !is_hit) begin
            victim_q <= pick;
            vtag_q   <= way_tag[pick];
            vline_q  <= way_rline[pick];
        end
        if ((state == S_FILL) && mem_rvalid) begin
            fill_q.words[beat] <= mem_rdata;
        end
        if (((state == S_CMP) && is_hit) || fill_done) begin
            rdata_q <= merged.words[off_q];
        end
    end

endmodule

/* hdl/dcache_way.sv */
`timescale 1ns/100ps

module dcache_way
    import dcache_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                en,
    input  logic                we,
    input  logic [SET_BITS-1:0] set,
    input  line_t               wline,
    input  logic [TAG_BITS-1:0] wtag,
    input  logic                wdirty,
    output logic                valid,
    output logic                dirty,
    output logic [TAG_BITS-1:0] tag,
    output line_t               rline
);

    logic [SET_NUM-1:0]   valid_q;
    logic [SET_NUM-1:0]   dirty_q;
    logic [TAG_BITS-1:0]  tag_mem [SET_NUM];
    logic [LINE_BITS-1:0] line_mem [SET_NUM];
    logic                 wr;

    assign wr = en && we;

    // per-set flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr) begin
            valid_q[set] <= 1'b1;
            dirty_q[set] <= wdirty;
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            tag_mem[set]  <= wtag;
            line_mem[set] <= wline.flat;
        end
    end

    // registered read, one cycle after the set is presented
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
            dirty <= 1'b0;
        end else begin
            valid <= valid_q[set];
            dirty <= dirty_q[set];
        end
    end

    always_ff @(posedge clk) begin
        tag        <= tag_mem[set];
        rline.flat <= line_mem[set];
    end

endmodule

/* hdl/victim_lfsr.sv */
`timescale 1ns/100ps

module victim_lfsr #(
    parameter int WAY_NUM = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,
    output logic [$clog2(WAY_NUM)-1:0] rand_way
);

    logic [7:0] lfsr;

    // x^8 + x^6 + x^5 + x^4 + 1, maximal length
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr <= 8'hA5;
        end else begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    assign rand_way = lfsr[$clog2(WAY_NUM)-1:0];

endmodule

/* hdl/dcache_pkg.sv */
package dcache_pkg;

    // address split: tag | set | word offset | byte
    localparam int ADDR_BITS   = 32;
    localparam int WORD_BITS   = 32;
    localparam int LINE_WORDS  = 4;
    localparam int LINE_BITS   = LINE_WORDS * WORD_BITS;
    localparam int SET_BITS    = 6;
    localparam int SET_NUM     = 1 << SET_BITS;
    localparam int OFFSET_BITS = 2;
    localparam int TAG_BITS    = ADDR_BITS - SET_BITS - OFFSET_BITS - 2;

    typedef logic [WORD_BITS-1:0] word_t;

    // whole line for array writes, word view for select and merge
    typedef union packed {
        logic [LINE_BITS-1:0]         flat;
        word_t [LINE_WORDS-1:0]       words;
    } line_t;

endpackage
